// ==== rtl/blob_pkg.sv ====
`default_nettype none

package blob_pkg;

	localparam int unsigned ADDR_W = 18;
	localparam int unsigned PIXEL_W = 32;
	localparam int unsigned COORD_W = 9;
	localparam int unsigned LABEL_W = 16;
	localparam int unsigned SIZE_W = 17;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [PIXEL_W-1:0] pixel_t; // Zero is an unlabeled foreground pixel
	typedef logic [COORD_W-1:0] coord_t;
	typedef logic [LABEL_W-1:0] label_t;
	typedef logic [2*COORD_W-1:0] stack_entry_t; // {x, y}
	typedef logic [SIZE_W-1:0] blob_size_t;

	localparam label_t FIRST_LABEL = 16'd2;

	// Region records, two words per label
	localparam addr_t RECORD_BASE = 18'd200000;
	localparam addr_t RECORD_WORDS = 18'd2;
	localparam addr_t REC_SIZE_WORD = 18'd0;
	localparam addr_t REC_BOX_WORD = 18'd1; // {min_x, min_y, max_x, max_y}

	typedef enum logic [2:0] {
		S_IDLE, S_QUALIFY, S_REQUEST, S_CHECK, S_FILL, S_REC_SIZE, S_REC_BOX, S_DONE
	} scan_state_t;

	typedef enum logic [3:0] {
		F_IDLE, F_PUSH_SEED, F_POP_REQ, F_POP, F_UP_READ, F_UP_CHECK, F_DOWN_READ,
		F_DOWN_CHECK, F_LEFT_READ, F_LEFT_CHECK, F_RIGHT_READ, F_RIGHT_CHECK, F_NEXT
	} fill_state_t;

	function automatic addr_t pixel_addr(coord_t x, coord_t y, int unsigned width);
		return addr_t'(y * width + x);
	endfunction

	// Strictly inside the border margin
	function automatic logic is_inside(coord_t x, coord_t y, int unsigned width,
		int unsigned height, int unsigned border);
		return (x > border) && (x < width - border) && (y > border) && (y < height - border);
	endfunction

endpackage

`default_nettype wire

// ==== rtl/blob_stack.sv ====
`default_nettype none

module blob_stack #(
	parameter int unsigned STACK_DEPTH = 2048
) (
	input wire modified_clock_two_div_by_two,
	input wire arst_n,
	input wire push,
	input wire pop,
	input wire blob_pkg::stack_entry_t push_entry,
	output blob_pkg::stack_entry_t top_entry,
	output logic empty
);
	import blob_pkg::*;

	localparam int unsigned AW = $clog2(STACK_DEPTH);

	stack_entry_t mem [STACK_DEPTH];
	logic [AW:0] sp; // Points at the next free slot
	logic [AW:0] sp_dec;

	assign sp_dec = sp - 1'b1;
	assign empty = (sp == '0);

	always_ff @(posedge modified_clock_two_div_by_two or negedge arst_n) begin
		if (!arst_n) begin
			sp <= '0;
		end else if (push) begin
			sp <= sp + 1'b1;
		end else if (pop) begin
			sp <= sp_dec;
		end
	end

	// Entry RAM and read port
	always_ff @(posedge modified_clock_two_div_by_two) begin
		if (push) begin
			mem[sp[AW-1:0]] <= push_entry;
		end
		if (pop) begin
			top_entry <= mem[sp_dec[AW-1:0]]; // Valid the cycle after pop
		end
	end

endmodule

`default_nettype wire

// ==== rtl/blob_stats.sv ====
`default_nettype none

module blob_stats (
	input wire modified_clock_two_div_by_two,
	input wire arst_n,
	input wire seed_valid,
	input wire pixel_strobe,
	input wire blob_pkg::coord_t pixel_x,
	input wire blob_pkg::coord_t pixel_y,
	output blob_pkg::blob_size_t blob_size,
	output blob_pkg::coord_t min_x,
	output blob_pkg::coord_t min_y,
	output blob_pkg::coord_t max_x,
	output blob_pkg::coord_t max_y
);
	import blob_pkg::*;

	logic first_pixel;

	assign first_pixel = (blob_size == '0);

	always_ff @(posedge modified_clock_two_div_by_two or negedge arst_n) begin
		if (!arst_n) begin
			blob_size <= '0;
			min_x <= '0;
			min_y <= '0;
			max_x <= '0;
			max_y <= '0;
		end else if (seed_valid) begin
			blob_size <= '0; // New region
		end else if (pixel_strobe) begin
			blob_size <= blob_size + 1'b1;
			if (first_pixel) begin
				min_x <= pixel_x;
				min_y <= pixel_y;
				max_x <= pixel_x;
				max_y <= pixel_y;
			end else begin
				// Widen the box
				if (pixel_x < min_x) begin
					min_x <= pixel_x;
				end
				if (pixel_y < min_y) begin
					min_y <= pixel_y;
				end
				if (pixel_x > max_x) begin
					max_x <= pixel_x;
				end
				if (pixel_y > max_y) begin
					max_y <= pixel_y;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/flood_fill.sv ====
`default_nettype none

module flood_fill #(
	parameter int unsigned FRAME_WIDTH = 320,
	parameter int unsigned FRAME_HEIGHT = 240,
	parameter int unsigned BORDER = 7
) (
	input wire modified_clock_two_div_by_two,
	input wire arst_n,
	input wire seed_valid,
	input wire blob_pkg::coord_t seed_x,
	input wire blob_pkg::coord_t seed_y,
	input wire blob_pkg::label_t fill_label,
	input wire blob_pkg::pixel_t data_read,
	output blob_pkg::addr_t fill_address,
	output logic fill_wren,
	output blob_pkg::pixel_t fill_data,
	output logic fill_done,
	output logic push,
	output logic pop,
	output blob_pkg::stack_entry_t push_entry,
	input wire blob_pkg::stack_entry_t top_entry,
	input wire empty,
	output logic pixel_strobe,
	output blob_pkg::coord_t pixel_x,
	output blob_pkg::coord_t pixel_y
);
	import blob_pkg::*;

	fill_state_t state;
	coord_t cur_x;
	coord_t cur_y;
	coord_t left_x;
	coord_t right_x;
	coord_t up_y;
	coord_t down_y;
	coord_t top_x;
	coord_t top_y;
	label_t label;
	logic span_left;
	logic span_right;
	logic zero_read;
	logic pixel_free;
	logic left_free;
	logic right_free;

	assign left_x = cur_x - 1'b1;
	assign right_x = cur_x + 1'b1;
	assign up_y = cur_y - 1'b1;
	assign down_y = cur_y + 1'b1;
	assign top_x = top_entry[2*COORD_W-1 -: COORD_W];
	assign top_y = top_entry[COORD_W-1:0];

	// All checks look at the word read in the previous cycle
	assign zero_read = (data_read == '0);
	assign pixel_free = zero_read && is_inside(cur_x, cur_y, FRAME_WIDTH, FRAME_HEIGHT, BORDER);
	assign left_free = zero_read && is_inside(left_x, cur_y, FRAME_WIDTH, FRAME_HEIGHT, BORDER);
	assign right_free = zero_read && is_inside(right_x, cur_y, FRAME_WIDTH, FRAME_HEIGHT, BORDER);

	assign fill_data = pixel_t'(label);
	assign pixel_x = cur_x; // Stable while the strobe is high
	assign pixel_y = cur_y;

	always_ff @(posedge modified_clock_two_div_by_two) begin
		if (state == F_IDLE && seed_valid) begin
			label <= fill_label;
		end
	end

	always_ff @(posedge modified_clock_two_div_by_two or negedge arst_n) begin
		if (!arst_n) begin
			state <= F_IDLE;
			cur_x <= '0;
			cur_y <= '0;
			span_left <= 1'b0;
			span_right <= 1'b0;
			fill_address <= '0;
			fill_wren <= 1'b0;
			fill_done <= 1'b0;
			push <= 1'b0;
			pop <= 1'b0;
			push_entry <= '0;
			pixel_strobe <= 1'b0;
		end else begin
			push <= 1'b0;
			pop <= 1'b0;
			fill_done <= 1'b0;
			pixel_strobe <= 1'b0;
			case (state)
				F_IDLE: begin
					if (seed_valid) begin
						push <= 1'b1;
						push_entry <= {seed_x, seed_y};
						state <= F_PUSH_SEED;
					end
				end
				F_PUSH_SEED: begin
					pop <= 1'b1; // Seed lands at the end of this cycle
					state <= F_POP_REQ;
				end
				F_POP_REQ: state <= F_POP;
				F_POP: begin
					cur_x <= top_x;
					cur_y <= top_y;
					fill_address <= pixel_addr(top_x, top_y, FRAME_WIDTH);
					span_left <= 1'b0;
					span_right <= 1'b0;
					state <= F_UP_READ;
				end
				F_UP_READ: state <= F_UP_CHECK;
				F_UP_CHECK: begin
					if (pixel_free) begin
						cur_y <= up_y;
						fill_address <= pixel_addr(cur_x, up_y, FRAME_WIDTH);
						state <= F_UP_READ;
					end else begin
						// Top edge found, step back down
						cur_y <= down_y;
						fill_address <= pixel_addr(cur_x, down_y, FRAME_WIDTH);
						state <= F_DOWN_READ;
					end
				end
				F_DOWN_READ: state <= F_DOWN_CHECK;
				F_DOWN_CHECK: begin
					if (pixel_free) begin
						pixel_strobe <= 1'b1;
						fill_address <= pixel_addr(left_x, cur_y, FRAME_WIDTH);
						state <= F_LEFT_READ;
					end else begin
						state <= F_NEXT;
					end
				end
				F_LEFT_READ: begin
					fill_address <= pixel_addr(cur_x, cur_y, FRAME_WIDTH);
					fill_wren <= 1'b1; // Label write overlaps the left check
					state <= F_LEFT_CHECK;
				end
				F_LEFT_CHECK: begin
					fill_wren <= 1'b0;
					fill_address <= pixel_addr(right_x, cur_y, FRAME_WIDTH);
					if (left_free && !span_left) begin
						push <= 1'b1;
						push_entry <= {left_x, cur_y};
						span_left <= 1'b1;
					end else if (!zero_read) begin
						span_left <= 1'b0;
					end
					state <= F_RIGHT_READ;
				end
				F_RIGHT_READ: begin
					fill_address <= pixel_addr(cur_x, down_y, FRAME_WIDTH);
					state <= F_RIGHT_CHECK;
				end
				F_RIGHT_CHECK: begin
					if (right_free && !span_right) begin
						push <= 1'b1;
						push_entry <= {right_x, cur_y};
						span_right <= 1'b1;
					end else if (!zero_read) begin
						span_right <= 1'b0;
					end
					cur_y <= down_y; // Pixel below is already being read
					state <= F_DOWN_CHECK;
				end
				F_NEXT: begin
					if (!empty) begin
						pop <= 1'b1;
						state <= F_POP_REQ;
					end else begin
						fill_done <= 1'b1;
						state <= F_IDLE;
					end
				end
				default: state <= F_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/frame_scanner.sv ====
`default_nettype none

module frame_scanner #(
	parameter int unsigned FRAME_WIDTH = 320,
	parameter int unsigned FRAME_HEIGHT = 240,
	parameter int unsigned BORDER = 7
) (
	input wire modified_clock_two_div_by_two,
	input wire arst_n,
	input wire enable,
	input wire blob_pkg::pixel_t data_read,
	input wire blob_pkg::addr_t fill_address,
	input wire fill_wren,
	input wire blob_pkg::pixel_t fill_data,
	input wire fill_done,
	input wire blob_pkg::blob_size_t blob_size,
	input wire blob_pkg::coord_t min_x,
	input wire blob_pkg::coord_t min_y,
	input wire blob_pkg::coord_t max_x,
	input wire blob_pkg::coord_t max_y,
	output blob_pkg::addr_t address,
	output logic wren,
	output blob_pkg::pixel_t data_write,
	output logic done,
	output blob_pkg::label_t blob_count,
	output logic seed_valid,
	output blob_pkg::coord_t seed_x,
	output blob_pkg::coord_t seed_y,
	output blob_pkg::label_t fill_label
);
	import blob_pkg::*;

	localparam coord_t FIRST_X = coord_t'(BORDER + 1);
	localparam coord_t LAST_X = coord_t'(FRAME_WIDTH - BORDER - 1);
	localparam coord_t FIRST_Y = coord_t'(BORDER + 1);
	localparam coord_t LAST_Y = coord_t'(FRAME_HEIGHT - BORDER - 1);

	scan_state_t state;
	coord_t scan_x;
	coord_t scan_y;
	coord_t next_x;
	coord_t next_y;
	logic last_pixel;
	addr_t scan_address;
	logic scan_wren;
	pixel_t scan_data;
	label_t next_label; // Label of the next region found
	addr_t record_addr;

	assign last_pixel = (scan_x == LAST_X) && (scan_y == LAST_Y);
	assign record_addr = RECORD_BASE + addr_t'(next_label) * RECORD_WORDS;

	always_comb begin
		if (scan_x == LAST_X) begin
			next_x = FIRST_X;
			next_y = scan_y + 1'b1;
		end else begin
			next_x = scan_x + 1'b1;
			next_y = scan_y;
		end
	end

	assign seed_x = scan_x;
	assign seed_y = scan_y;
	assign fill_label = next_label;
	assign blob_count = next_label - FIRST_LABEL;
	assign done = (state == S_DONE);

	// Memory port owner
	always_comb begin
		if (state == S_FILL) begin
			address = fill_address;
			wren = fill_wren;
			data_write = fill_data;
		end else begin
			address = scan_address;
			wren = scan_wren;
			data_write = scan_data;
		end
	end

	always_ff @(posedge modified_clock_two_div_by_two or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			scan_x <= '0;
			scan_y <= '0;
			scan_address <= '0;
			scan_wren <= 1'b0;
			scan_data <= '0;
			next_label <= FIRST_LABEL;
			seed_valid <= 1'b0;
		end else begin
			seed_valid <= 1'b0;
			case (state)
				S_IDLE: begin
					if (enable) begin
						state <= S_QUALIFY;
					end
				end
				S_QUALIFY: begin
					if (enable) begin
						// Second high sample in a row
						scan_x <= FIRST_X;
						scan_y <= FIRST_Y;
						scan_address <= pixel_addr(FIRST_X, FIRST_Y, FRAME_WIDTH);
						next_label <= FIRST_LABEL;
						state <= S_REQUEST;
					end else begin
						state <= S_IDLE;
					end
				end
				S_REQUEST: state <= S_CHECK;
				S_CHECK: begin
					if (data_read == '0) begin
						seed_valid <= 1'b1;
						state <= S_FILL;
					end else if (last_pixel) begin
						state <= S_DONE;
					end else begin
						scan_x <= next_x;
						scan_y <= next_y;
						scan_address <= pixel_addr(next_x, next_y, FRAME_WIDTH);
						state <= S_REQUEST;
					end
				end
				S_FILL: begin
					if (fill_done) begin
						scan_address <= record_addr + REC_SIZE_WORD;
						scan_data <= pixel_t'(blob_size);
						scan_wren <= 1'b1;
						state <= S_REC_SIZE;
					end
				end
				S_REC_SIZE: begin
					scan_address <= record_addr + REC_BOX_WORD;
					scan_data <= {min_x[7:0], min_y[7:0], max_x[7:0], max_y[7:0]};
					state <= S_REC_BOX;
				end
				S_REC_BOX: begin
					scan_wren <= 1'b0;
					next_label <= next_label + 1'b1;
					// Resume after the seed
					if (last_pixel) begin
						state <= S_DONE;
					end else begin
						scan_x <= next_x;
						scan_y <= next_y;
						scan_address <= pixel_addr(next_x, next_y, FRAME_WIDTH);
						state <= S_REQUEST;
					end
				end
				S_DONE: begin
					if (!enable) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/blob_extraction.sv ====
`default_nettype none

module blob_extraction #(
	parameter int unsigned FRAME_WIDTH = 320,
	parameter int unsigned FRAME_HEIGHT = 240,
	parameter int unsigned BORDER = 7,
	parameter int unsigned STACK_DEPTH = 2048
) (
	input wire modified_clock_two_div_by_two,
	input wire arst_n,
	input wire enable,
	input wire blob_pkg::pixel_t data_read,
	output blob_pkg::addr_t address,
	output logic wren,
	output blob_pkg::pixel_t data_write,
	output logic done,
	output blob_pkg::label_t blob_count
);
	import blob_pkg::*;

	// Scanner and fill engine
	addr_t fill_address;
	logic fill_wren;
	pixel_t fill_data;
	logic fill_done;
	logic seed_valid;
	coord_t seed_x;
	coord_t seed_y;
	label_t fill_label;

	// Fill engine and stack
	logic push;
	logic pop;
	stack_entry_t push_entry;
	stack_entry_t top_entry;
	logic empty;

	// Region statistics
	logic pixel_strobe;
	coord_t pixel_x;
	coord_t pixel_y;
	blob_size_t blob_size;
	coord_t min_x;
	coord_t min_y;
	coord_t max_x;
	coord_t max_y;

	frame_scanner #(
		.FRAME_WIDTH(FRAME_WIDTH),
		.FRAME_HEIGHT(FRAME_HEIGHT),
		.BORDER(BORDER)
	) u_frame_scanner (
		.modified_clock_two_div_by_two(modified_clock_two_div_by_two),
		.arst_n(arst_n),
		.enable(enable),
		.data_read(data_read),
		.fill_address(fill_address),
		.fill_wren(fill_wren),
		.fill_data(fill_data),
		.fill_done(fill_done),
		.blob_size(blob_size),
		.min_x(min_x),
		.min_y(min_y),
		.max_x(max_x),
		.max_y(max_y),
		.address(address),
		.wren(wren),
		.data_write(data_write),
		.done(done),
		.blob_count(blob_count),
		.seed_valid(seed_valid),
		.seed_x(seed_x),
		.seed_y(seed_y),
		.fill_label(fill_label)
	);

	flood_fill #(
		.FRAME_WIDTH(FRAME_WIDTH),
		.FRAME_HEIGHT(FRAME_HEIGHT),
		.BORDER(BORDER)
	) u_flood_fill (
		.modified_clock_two_div_by_two(modified_clock_two_div_by_two),
		.arst_n(arst_n),
		.seed_valid(seed_valid),
		.seed_x(seed_x),
		.seed_y(seed_y),
		.fill_label(fill_label),
		.data_read(data_read),
		.fill_address(fill_address),
		.fill_wren(fill_wren),
		.fill_data(fill_data),
		.fill_done(fill_done),
		.push(push),
		.pop(pop),
		.push_entry(push_entry),
		.top_entry(top_entry),
		.empty(empty),
		.pixel_strobe(pixel_strobe),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y)
	);

	blob_stack #(
		.STACK_DEPTH(STACK_DEPTH)
	) u_blob_stack (
		.modified_clock_two_div_by_two(modified_clock_two_div_by_two),
		.arst_n(arst_n),
		.push(push),
		.pop(pop),
		.push_entry(push_entry),
		.top_entry(top_entry),
		.empty(empty)
	);

	blob_stats u_blob_stats (
		.modified_clock_two_div_by_two(modified_clock_two_div_by_two),
		.arst_n(arst_n),
		.seed_valid(seed_valid),
		.pixel_strobe(pixel_strobe),
		.pixel_x(pixel_x),
		.pixel_y(pixel_y),
		.blob_size(blob_size),
		.min_x(min_x),
		.min_y(min_y),
		.max_x(max_x),
		.max_y(max_y)
	);

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`default_nettype none

module tb_clock #(
	parameter int unsigned PERIOD_NS = 20,
	parameter int unsigned RESET_CYCLES = 2
) (
	output logic clk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 arst_n = 1'b1; // Released clear of the edge
	end

endmodule

`default_nettype wire

// ==== tb/tb_blob_extraction.sv ====
`default_nettype none

module tb_blob_extraction;
	timeunit 1ns;
	timeprecision 100ps;
	import blob_pkg::*;

	localparam int unsigned FRAME_WIDTH = 32;
	localparam int unsigned FRAME_HEIGHT = 24;
	localparam int unsigned BORDER = 2;
	localparam int unsigned STACK_DEPTH = 256;
	localparam int unsigned FRAME_WORDS = FRAME_WIDTH * FRAME_HEIGHT;
	localparam int unsigned MEM_WORDS = 1 << ADDR_W;
	localparam int unsigned MAX_LABELS = FRAME_WORDS + FIRST_LABEL;
	localparam int unsigned CYCLE_LIMIT = 5 * FRAME_WIDTH * FRAME_HEIGHT * 40; // Five runs

	logic modified_clock_two_div_by_two;
	logic arst_n;
	logic enable;
	pixel_t data_read = '0;
	addr_t address;
	logic wren;
	pixel_t data_write;
	logic done;
	label_t blob_count;

	pixel_t mem [MEM_WORDS];
	pixel_t exp_frame [FRAME_WORDS]; // Reference labeler output
	blob_size_t exp_size [MAX_LABELS];
	pixel_t exp_box [MAX_LABELS];
	int unsigned exp_count;
	logic [31:0] lcg_state;
	int unsigned cycle_count = 0;
	int unsigned check_count;
	int unsigned error_count;

	tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(2)) clock0 (
		.clk(modified_clock_two_div_by_two),
		.arst_n(arst_n)
	);

	blob_extraction #(
		.FRAME_WIDTH(FRAME_WIDTH),
		.FRAME_HEIGHT(FRAME_HEIGHT),
		.BORDER(BORDER),
		.STACK_DEPTH(STACK_DEPTH)
	) dut0 (
		.modified_clock_two_div_by_two(modified_clock_two_div_by_two),
		.arst_n(arst_n),
		.enable(enable),
		.data_read(data_read),
		.address(address),
		.wren(wren),
		.data_write(data_write),
		.done(done),
		.blob_count(blob_count)
	);

	// External memory with a one-cycle read
	always @(posedge modified_clock_two_div_by_two) begin : memory_model
		addr_t a;
		pixel_t rd;
		a = address;
		rd = mem[a];
		if (wren) begin
			mem[a] = data_write;
		end
		#2 data_read = rd;
	end

	always @(posedge modified_clock_two_div_by_two) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the DUT did not finish within %0d cycles", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic pixel_t background_word(int unsigned a);
		return {14'h2c5, a[ADDR_W-1:0]}; // Never zero
	endfunction

	function automatic int pixel_index(int x, int y);
		return y * FRAME_WIDTH + x;
	endfunction

	function automatic bit inside_margin(int x, int y);
		return x > int'(BORDER) && x < int'(FRAME_WIDTH - BORDER) &&
			y > int'(BORDER) && y < int'(FRAME_HEIGHT - BORDER);
	endfunction

	task automatic clear_memory();
		for (int unsigned a = 0; a < MEM_WORDS; a++) begin
			mem[a] = background_word(a);
		end
	endtask

	task automatic fill_box(int x0, int y0, int x1, int y1);
		for (int y = y0; y <= y1; y++) begin
			for (int x = x0; x <= x1; x++) begin
				mem[pixel_index(x, y)] = '0;
			end
		end
	endtask

	// Breadth-first labeling of the frame now in memory
	task automatic compute_reference();
		int pending[$];
		int p;
		int px;
		int py;
		int nx;
		int ny;
		int lo_x;
		int lo_y;
		int hi_x;
		int hi_y;
		int unsigned lbl;
		blob_size_t size;
		lbl = FIRST_LABEL;
		for (int a = 0; a < FRAME_WORDS; a++) begin
			exp_frame[a] = mem[a];
		end
		for (int y = 0; y < FRAME_HEIGHT; y++) begin
			for (int x = 0; x < FRAME_WIDTH; x++) begin
				if (inside_margin(x, y) && exp_frame[pixel_index(x, y)] == '0) begin
					exp_frame[pixel_index(x, y)] = pixel_t'(lbl);
					pending.push_back(pixel_index(x, y));
					size = '0;
					lo_x = x;
					hi_x = x;
					lo_y = y;
					hi_y = y;
					while (pending.size() > 0) begin
						p = pending.pop_front();
						px = p % FRAME_WIDTH;
						py = p / FRAME_WIDTH;
						size = size + 1'b1;
						lo_x = (px < lo_x) ? px : lo_x;
						hi_x = (px > hi_x) ? px : hi_x;
						lo_y = (py < lo_y) ? py : lo_y;
						hi_y = (py > hi_y) ? py : hi_y;
						for (int k = 0; k < 4; k++) begin
							nx = px + ((k == 0) ? -1 : (k == 1) ? 1 : 0);
							ny = py + ((k == 2) ? -1 : (k == 3) ? 1 : 0);
							if (inside_margin(nx, ny) && exp_frame[pixel_index(nx, ny)] == '0) begin
								exp_frame[pixel_index(nx, ny)] = pixel_t'(lbl);
								pending.push_back(pixel_index(nx, ny));
							end
						end
					end
					exp_size[lbl] = size;
					exp_box[lbl] = {8'(lo_x), 8'(lo_y), 8'(hi_x), 8'(hi_y)};
					lbl++;
				end
			end
		end
		exp_count = lbl - FIRST_LABEL;
	endtask

	task automatic compare_value(string what, logic [31:0] got, logic [31:0] want);
		check_count++;
		assert (got == want) else begin
			error_count++;
			$display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic check_against_reference(string test);
		int unsigned rec;
		for (int a = 0; a < FRAME_WORDS; a++) begin
			compare_value($sformatf("%s pixel (%0d,%0d)", test, a % FRAME_WIDTH, a / FRAME_WIDTH),
				mem[a], exp_frame[a]);
		end
		compare_value({test, " blob_count"}, 32'(blob_count), exp_count);
		for (int unsigned l = FIRST_LABEL; l < FIRST_LABEL + exp_count; l++) begin
			rec = RECORD_BASE + l * RECORD_WORDS;
			compare_value($sformatf("%s size of label %0d", test, l), mem[rec], 32'(exp_size[l]));
			compare_value($sformatf("%s box of label %0d", test, l), mem[rec + 1], exp_box[l]);
		end
	endtask

	task automatic run_labeling();
		@(posedge modified_clock_two_div_by_two);
		#2 enable = 1'b1;
		@(negedge modified_clock_two_div_by_two);
		while (done !== 1'b1) begin
			@(negedge modified_clock_two_div_by_two);
		end
	endtask

	task automatic release_enable();
		int unsigned waited;
		@(posedge modified_clock_two_div_by_two);
		#2 enable = 1'b0;
		waited = 0;
		while (done === 1'b1 && waited < 4) begin
			@(negedge modified_clock_two_div_by_two);
			waited++;
		end
		check_count++;
		assert (done === 1'b0) else begin
			error_count++;
			$display("done is still high %0d cycles after enable went low", waited);
		end
	endtask

	task automatic test_empty_frame();
		int unsigned changed;
		clear_memory();
		run_labeling();
		compare_value("empty blob_count", 32'(blob_count), 0);
		changed = 0;
		for (int unsigned a = 0; a < MEM_WORDS; a++) begin
			if (mem[a] != background_word(a)) begin
				changed++;
			end
		end
		compare_value("empty changed words", changed, 0);
		release_enable();
	endtask

	task automatic test_solid_rectangle();
		clear_memory();
		fill_box(5, 4, 12, 9);
		compute_reference();
		run_labeling();
		for (int y = 4; y <= 9; y++) begin
			for (int x = 5; x <= 12; x++) begin
				compare_value("rectangle pixel", mem[pixel_index(x, y)], 32'(FIRST_LABEL));
			end
		end
		compare_value("rectangle size", mem[RECORD_BASE + 4], 48);
		compare_value("rectangle box", mem[RECORD_BASE + 5], {8'd5, 8'd4, 8'd12, 8'd9});
		check_against_reference("rectangle");
		release_enable();
	endtask

	task automatic test_u_and_bar();
		clear_memory();
		fill_box(5, 5, 5, 12); // U legs and base
		fill_box(11, 5, 11, 12);
		fill_box(5, 12, 11, 12);
		for (int i = 0; i < 8; i++) begin
			fill_box(16 + i, 5 + i, 17 + i, 5 + i); // Staircase bar
		end
		compute_reference();
		run_labeling();
		compare_value("U left leg", mem[pixel_index(5, 5)], 2);
		compare_value("U right leg", mem[pixel_index(11, 5)], 2);
		compare_value("bar top", mem[pixel_index(16, 5)], 3);
		compare_value("bar bottom", mem[pixel_index(24, 12)], 3);
		check_against_reference("u_and_bar");
		release_enable();
	endtask

	// Leaves enable high so the restart test can drop it
	task automatic test_border_margin();
		clear_memory();
		mem[pixel_index(1, 1)] = '0;
		mem[pixel_index(2, 12)] = '0;
		mem[pixel_index(30, 5)] = '0;
		mem[pixel_index(31, 23)] = '0;
		fill_box(0, 10, 6, 13);
		fill_box(15, 21, 15, 22);
		compute_reference();
		run_labeling();
		compare_value("margin corner", mem[pixel_index(1, 1)], 0);
		compare_value("margin part of region", mem[pixel_index(2, 10)], 0);
		compare_value("inside part of region", mem[pixel_index(3, 10)], 2);
		compare_value("margin below", mem[pixel_index(15, 22)], 0);
		compare_value("last inside row", mem[pixel_index(15, 21)], 3);
		compare_value("clipped size", mem[RECORD_BASE + 4], 16);
		compare_value("clipped box", mem[RECORD_BASE + 5], {8'd3, 8'd10, 8'd6, 8'd13});
		check_against_reference("margin");
	endtask

	task automatic test_restart();
		logic [31:0] r;
		release_enable();
		clear_memory();
		for (int a = 0; a < FRAME_WORDS; a++) begin
			r = lcg_next();
			if (r[31:24] < 8'd128) begin
				mem[a] = '0;
			end
		end
		compute_reference();
		run_labeling();
		$display("Random frame holds %0d regions", exp_count);
		check_against_reference("random");
		release_enable();
	endtask

	initial begin
		enable = 1'b0;
		lcg_state = 32'h70057770;
		check_count = 0;
		error_count = 0;
		clear_memory();
		wait (arst_n === 1'b1);
		@(negedge modified_clock_two_div_by_two);
		compare_value("wren after reset", 32'(wren), 0);
		compare_value("done after reset", 32'(done), 0);
		compare_value("address after reset", 32'(address), 0);
		compare_value("data_write after reset", data_write, 0);
		test_empty_frame();
		test_solid_rectangle();
		test_u_and_bar();
		test_border_margin();
		test_restart();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== blob_extraction.f ====
rtl/blob_pkg.sv
rtl/blob_stack.sv
rtl/blob_stats.sv
rtl/flood_fill.sv
rtl/frame_scanner.sv
rtl/blob_extraction.sv
tb/tb_clock.sv
tb/tb_blob_extraction.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_blob_extraction \
	-Mdir obj_dir -f blob_extraction.f || exit 1
sim_out=$(./obj_dir/Vtb_blob_extraction)
echo "$sim_out"
echo "$sim_out" | grep -qx "NO ERRORS" && echo "Simulation passed" || {
	echo "Simulation failed"
	exit 1
}
